/* Makefile */
# Verilator flow for the camera display pipeline

TOP := tb_cam_display
SRCS := $(wildcard src/*.sv) $(wildcard test/*.sv)

.PHONY: all run lint clean

all: run

obj_dir/$(TOP): build.f $(SRCS)
	verilator --binary --timing -j 0 -f build.f --top-module $(TOP) -o $(TOP)

# result is taken from the log, not from the exit code
run: obj_dir/$(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "TESTS FAILED" sim.log; then \
		echo "simulation reported failures, see sim.log"; \
		exit 1; \
	fi
	@if ! grep -q "TESTS PASSED" sim.log; then \
		echo "simulation ended without a result, see sim.log"; \
		exit 1; \
	fi

lint:
	verilator --lint-only --timing -Wall -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

/* build.f */
src/video_pkg.sv
src/pixel_pkg.sv
src/raster_scan.sv
src/frame_buffer.sv
src/pixel_convert.sv
src/output_select.sv
src/cam_display_top.sv
test/tb_cam_display.sv

/* src/cam_display_top.sv */
`default_nettype none
`timescale 1ns/10ps

module cam_display_top #(
    parameter int H_ACTIVE    = 320,
    parameter int H_TOTAL     = 400,
    parameter int V_ACTIVE    = 240,
    parameter int V_TOTAL     = 262,
    parameter int BANK0_DEPTH = 65536,
    parameter int FRAME_WORDS = H_ACTIVE * V_ACTIVE
) (
    input  logic                    clk_25MHz,
    input  logic                    rst_n,
    input  video_pkg::fb_write_t    wr,
    input  video_pkg::filter_mode_t filter_mode,
    output pixel_pkg::pixel_out_t   pix,
    output logic                    vsync,
    output logic                    display_enable
);

    import video_pkg::*;
    import pixel_pkg::*;

    // scanner to frame buffer
    frame_addr_t rd_addr;
    logic        rd_en;

    // frame buffer to converter, two cycles after the request
    rgb565_t     fb_data;
    logic        fb_valid;
    frame_addr_t fb_addr;

    // converter to output stage
    rgb888_t     cv_rgb;
    gray_t       cv_gray;
    logic        cv_valid;
    frame_addr_t cv_addr;

    // ======================================================================
    // scan -> read -> convert -> select, four cycles end to end
    // ======================================================================
    raster_scan #(
        .H_ACTIVE (H_ACTIVE),
        .H_TOTAL  (H_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .V_TOTAL  (V_TOTAL)
    ) raster_scan_i (
        .clk_25MHz      (clk_25MHz),
        .rst_n          (rst_n),
        .rd_addr        (rd_addr),
        .rd_en          (rd_en),
        .vsync          (vsync),
        .display_enable (display_enable)
    );

    frame_buffer #(
        .BANK0_DEPTH (BANK0_DEPTH),
        .FRAME_WORDS (FRAME_WORDS)
    ) frame_buffer_i (
        .clk_25MHz (clk_25MHz),
        .rst_n     (rst_n),
        .wr        (wr),
        .rd_addr   (rd_addr),
        .rd_en     (rd_en),
        .rd_data   (fb_data),
        .rd_valid  (fb_valid),
        .rd_addr_q (fb_addr)
    );

    pixel_convert pixel_convert_i (
        .clk_25MHz (clk_25MHz),
        .rst_n     (rst_n),
        .in_pix    (fb_data),
        .in_valid  (fb_valid),
        .in_addr   (fb_addr),
        .rgb       (cv_rgb),
        .gray      (cv_gray),
        .valid     (cv_valid),
        .addr      (cv_addr)
    );

    output_select output_select_i (
        .clk_25MHz   (clk_25MHz),
        .rst_n       (rst_n),
        .vsync       (vsync),
        .filter_mode (filter_mode),
        .rgb         (cv_rgb),
        .gray        (cv_gray),
        .valid       (cv_valid),
        .addr        (cv_addr),
        .pix         (pix)
    );

endmodule

`default_nettype wire

/* src/frame_buffer.sv */
`default_nettype none
`timescale 1ns/10ps

module frame_buffer #(
    parameter int BANK0_DEPTH = 65536,
    parameter int FRAME_WORDS = 76800
) (
    input  logic                   clk_25MHz,
    input  logic                   rst_n,
    input  video_pkg::fb_write_t   wr,
    input  video_pkg::frame_addr_t rd_addr,
    input  logic                   rd_en,
    output pixel_pkg::rgb565_t     rd_data,
    output logic                   rd_valid,
    output video_pkg::frame_addr_t rd_addr_q
);

    import video_pkg::*;
    import pixel_pkg::*;

    // bank 1 holds whatever of the frame does not fit in bank 0
    localparam int BANK1_DEPTH = FRAME_WORDS - BANK0_DEPTH;
    localparam int B0_AW       = $clog2(BANK0_DEPTH);
    localparam int B1_AW       = $clog2(BANK1_DEPTH);

    // first frame address that lives in bank 1
    localparam frame_addr_t BANK1_BASE = frame_addr_t'(BANK0_DEPTH);

    rgb565_t bank0 [BANK0_DEPTH];
    rgb565_t bank1 [BANK1_DEPTH];

    logic             wr_hi;
    frame_addr_t      wr_off;
    logic [B0_AW-1:0] wr_idx0;
    logic [B1_AW-1:0] wr_idx1;

    logic             rd_hi;
    frame_addr_t      rd_off;
    logic [B0_AW-1:0] rd_idx0;
    logic [B1_AW-1:0] rd_idx1;

    rgb565_t          bank0_q;
    rgb565_t          bank1_q;
    logic             sel_q;
    logic             valid_q;
    frame_addr_t      addr_q;

    // ======================================================================
    // write split
    // ======================================================================
    assign wr_hi   = (wr.addr >= BANK1_BASE);
    assign wr_off  = wr.addr - BANK1_BASE;
    assign wr_idx0 = wr.addr[B0_AW-1:0];
    assign wr_idx1 = wr_off[B1_AW-1:0];

    // writer is never stalled
    always_ff @(posedge clk_25MHz) begin
        if (wr.valid && !wr_hi) begin
            bank0[wr_idx0] <= wr.data;
        end
        if (wr.valid && wr_hi) begin
            bank1[wr_idx1] <= wr.data;
        end
    end

    // ======================================================================
    // read split and two-stage read
    // ======================================================================
    assign rd_hi   = (rd_addr >= BANK1_BASE);
    assign rd_off  = rd_addr - BANK1_BASE;
    assign rd_idx0 = rd_addr[B0_AW-1:0];
    // park bank 1 on word 0 when the read targets bank 0
    assign rd_idx1 = rd_hi ? rd_off[B1_AW-1:0] : '0;

    // stage 1
    // both banks read, same-edge write returns the old word
    always_ff @(posedge clk_25MHz) begin
        bank0_q <= bank0[rd_idx0];
        bank1_q <= bank1[rd_idx1];
        sel_q   <= rd_hi;
        addr_q  <= rd_addr;
    end

    // stage 2 bank mux
    always_ff @(posedge clk_25MHz) begin
        rd_data   <= sel_q ? bank1_q : bank0_q;
        rd_addr_q <= addr_q;
    end

    // active flag follows the data through both stages
    always_ff @(posedge clk_25MHz) begin
        if (!rst_n) begin
            valid_q  <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            valid_q  <= rd_en;
            rd_valid <= valid_q;
        end
    end

endmodule

`default_nettype wire

/* src/output_select.sv */
`default_nettype none
`timescale 1ns/10ps

module output_select (
    input  logic                    clk_25MHz,
    input  logic                    rst_n,
    input  logic                    vsync,
    input  video_pkg::filter_mode_t filter_mode,
    input  pixel_pkg::rgb888_t      rgb,
    input  pixel_pkg::gray_t        gray,
    input  logic                    valid,
    input  video_pkg::frame_addr_t  addr,
    output pixel_pkg::pixel_out_t   pix
);

    import video_pkg::*;
    import pixel_pkg::*;

    rgb888_t sel_rgb;
    logic    pass;

    // ======================================================================
    // mode mux
    // ======================================================================
    always_comb begin
        case (filter_mode)
            // gray level copied onto all three channels
            MODE_GRAY: sel_rgb = '{r: gray, g: gray, b: gray};
            // orig and every unused code
            default:   sel_rgb = rgb;
        endcase
    end

    // pipeline is flushed while vsync is low
    assign pass = valid && vsync;

    // ======================================================================
    // output register
    // ======================================================================
    always_ff @(posedge clk_25MHz) begin
        if (!rst_n) begin
            pix <= '0;
        end else begin
            pix.valid <= pass;
            pix.addr  <= addr;
            // black outside valid pixels
            pix.rgb   <= pass ? sel_rgb : '0;
        end
    end

endmodule

`default_nettype wire

/* src/pixel_convert.sv */
`default_nettype none
`timescale 1ns/10ps

module pixel_convert (
    input  logic                   clk_25MHz,
    input  logic                   rst_n,
    input  pixel_pkg::rgb565_t     in_pix,
    input  logic                   in_valid,
    input  video_pkg::frame_addr_t in_addr,
    output pixel_pkg::rgb888_t     rgb,
    output pixel_pkg::gray_t       gray,
    output logic                   valid,
    output video_pkg::frame_addr_t addr
);

    import pixel_pkg::*;

    rgb888_t     wide;
    logic [15:0] r_w;
    logic [15:0] g_w;
    logic [15:0] b_w;
    logic [15:0] gray_sum;

    // ======================================================================
    // RGB565 to RGB888
    // ======================================================================
    // low bits filled with ones so full scale maps to 8'hff
    assign wide = '{
        r: {in_pix[15:11], 3'b111},
        g: {in_pix[10:5], 2'b11},
        b: {in_pix[4:0], 3'b111}
    };

    // zero-extend before shifting
    assign r_w = {8'd0, wide.r};
    assign g_w = {8'd0, wide.g};
    assign b_w = {8'd0, wide.b};

    // ======================================================================
    // gray = (76 R + 150 G + 26 B) / 256
    // ======================================================================
    // weights sum to 252, so the total stays below 2^16
    // 76 = 64+8+4, 150 = 128+16+4+2, 26 = 16+8+2
    assign gray_sum = (r_w << 6) + (r_w << 3) + (r_w << 2)
                    + (g_w << 7) + (g_w << 4) + (g_w << 2) + (g_w << 1)
                    + (b_w << 4) + (b_w << 3) + (b_w << 1);

    always_ff @(posedge clk_25MHz) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else begin
            valid <= in_valid;
        end
    end

    // blank payload outside the active area
    always_ff @(posedge clk_25MHz) begin
        if (in_valid) begin
            rgb  <= wide;
            gray <= gray_sum[15:8];
            addr <= in_addr;
        end else begin
            rgb  <= '0;
            gray <= '0;
            addr <= '0;
        end
    end

endmodule

`default_nettype wire

/* src/pixel_pkg.sv */
`default_nettype none

package pixel_pkg;

    // ======================================================================
    // pixel formats
    // ======================================================================

    // stored pixel
    // red 15:11, green 10:5, blue 4:0
    typedef logic [15:0] rgb565_t;

    // one 8-bit channel or gray level
    typedef logic [7:0] gray_t;

    // widened pixel, red in the top byte
    typedef struct packed {
        gray_t r;
        gray_t g;
        gray_t b;
    } rgb888_t;

    // ======================================================================
    // display stream
    // ======================================================================

    // one output pixel with its frame address
    typedef struct packed {
        logic                   valid;
        video_pkg::frame_addr_t addr;
        rgb888_t                rgb;
    } pixel_out_t;

endpackage

`default_nettype wire

/* src/raster_scan.sv */
`default_nettype none
`timescale 1ns/10ps

module raster_scan #(
    parameter int H_ACTIVE = 320,
    parameter int H_TOTAL  = 400,
    parameter int V_ACTIVE = 240,
    parameter int V_TOTAL  = 262
) (
    input  logic                   clk_25MHz,
    input  logic                   rst_n,
    output video_pkg::frame_addr_t rd_addr,
    output logic                   rd_en,
    output logic                   vsync,
    output logic                   display_enable
);

    // counter widths follow the total line and frame sizes
    localparam int H_W = $clog2(H_TOTAL);
    localparam int V_W = $clog2(V_TOTAL);

    localparam logic [H_W-1:0] H_ACT  = H_W'(H_ACTIVE);
    localparam logic [H_W-1:0] H_LAST = H_W'(H_TOTAL - 1);
    localparam logic [V_W-1:0] V_ACT  = V_W'(V_ACTIVE);
    localparam logic [V_W-1:0] V_LAST = V_W'(V_TOTAL - 1);

    logic [H_W-1:0] h_cnt;
    logic [V_W-1:0] v_cnt;
    logic           active;
    logic           frame_start;
    logic           vsync_q;

    // ======================================================================
    // horizontal and vertical counters
    // ======================================================================
    always_ff @(posedge clk_25MHz) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_LAST) begin
            // end of line, step to next line or wrap the frame
            h_cnt <= '0;
            v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // visible region is the top-left corner of the raster
    assign active      = (h_cnt < H_ACT) && (v_cnt < V_ACT);
    assign frame_start = (h_cnt == '0) && (v_cnt == '0);

    // ======================================================================
    // read request and sync
    // ======================================================================
    always_ff @(posedge clk_25MHz) begin
        if (!rst_n) begin
            rd_en   <= 1'b0;
            rd_addr <= '0;
            vsync   <= 1'b1;
        end else begin
            rd_en <= active;
            // low for the whole last line of the frame
            vsync <= (v_cnt != V_LAST);
            // linear address restarts at the first visible pixel
            if (active) begin
                rd_addr <= frame_start ? '0 : rd_addr + 1'b1;
            end
        end
    end

    // display enable latches on the first vsync rising edge
    always_ff @(posedge clk_25MHz) begin
        if (!rst_n) begin
            vsync_q        <= 1'b1;
            display_enable <= 1'b0;
        end else begin
            vsync_q <= vsync;
            if (!vsync_q && vsync) begin
                display_enable <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/video_pkg.sv */
`default_nettype none

package video_pkg;

    // ======================================================================
    // frame addressing
    // ======================================================================

    // 17 bits spans a 320x240 frame across both banks
    localparam int ADDR_W = 17;

    // linear pixel index in raster order
    typedef logic [ADDR_W-1:0] frame_addr_t;

    // display mode
    // codes other than gray show the original colour
    typedef enum logic [2:0] {
        MODE_ORIG = 3'd0,
        MODE_GRAY = 3'd1
    } filter_mode_t;

    // one writer transfer, taken on every edge with valid high
    typedef struct packed {
        logic        valid;
        frame_addr_t addr;
        // RGB565 word laid out as pixel_pkg::rgb565_t
        logic [15:0] data;
    } fb_write_t;

endpackage

`default_nettype wire

/* test/tb_cam_display.sv */
`default_nettype none
`timescale 1ns/10ps

module tb_cam_display;

    import video_pkg::*;
    import pixel_pkg::*;

    // ======================================================================
    // small raster where the frame spans both banks
    // ======================================================================
    localparam int H_ACTIVE    = 16;
    localparam int H_TOTAL     = 20;
    localparam int V_ACTIVE    = 12;
    localparam int V_TOTAL     = 14;
    localparam int BANK0_DEPTH = 128;
    localparam int FRAME_WORDS = 192;

    localparam int          CLK_PERIOD = 40;
    localparam int          DRIVE_SKEW = 2;
    localparam logic [31:0] SEED       = 32'h2482e788;
    localparam int          N_TESTS    = 8;
    // two frames per entry plus slack for reset and start-up
    localparam int WATCHDOG_NS = (N_TESTS + 2) * 2 * V_TOTAL * H_TOTAL * CLK_PERIOD;

    // scan request to pix in cycles
    localparam int PIPE_LATENCY = 4;
    // pixel 0 is requested at the start of line 0, vsync falls at the start of the last line
    localparam int FIRST_PIX_TO_VSYNC = (V_TOTAL - 1) * H_TOTAL - PIPE_LATENCY;

    typedef enum logic [1:0] {
        FILL_RANDOM,
        FILL_ONES,
        FILL_ZEROS,
        FILL_BOUNDARY
    } fill_kind_t;

    typedef struct packed {
        filter_mode_t mode;
        fill_kind_t   fill;
        logic         check_en;
    } test_entry_t;

    logic         clk_25MHz;
    logic         rst_n;
    fb_write_t    wr;
    filter_mode_t filter_mode;
    pixel_out_t   pix;
    logic         vsync;
    logic         display_enable;

    test_entry_t  tests [N_TESTS];
    rgb565_t      model [FRAME_WORDS];
    logic         vsync_prev;
    int           errors;
    int           test_errs;
    int           failed_tests;

    cam_display_top #(
        .H_ACTIVE    (H_ACTIVE),
        .H_TOTAL     (H_TOTAL),
        .V_ACTIVE    (V_ACTIVE),
        .V_TOTAL     (V_TOTAL),
        .BANK0_DEPTH (BANK0_DEPTH),
        .FRAME_WORDS (FRAME_WORDS)
    ) cam_display_top_i (
        .clk_25MHz      (clk_25MHz),
        .rst_n          (rst_n),
        .wr             (wr),
        .filter_mode    (filter_mode),
        .pix            (pix),
        .vsync          (vsync),
        .display_enable (display_enable)
    );

    initial begin
        clk_25MHz = 1'b0;
        forever #(CLK_PERIOD / 2) clk_25MHz = ~clk_25MHz;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the display stream did not finish all frames in time");
        $display("TESTS FAILED");
        $finish;
    end

    // ======================================================================
    // reference rules
    // ======================================================================
    // low bits padded with ones
    function automatic rgb888_t widen(input rgb565_t w);
        rgb888_t p;
        p.r = {w[15:11], 3'b111};
        p.g = {w[10:5], 2'b11};
        p.b = {w[4:0], 3'b111};
        return p;
    endfunction

    function automatic gray_t gray_level(input rgb888_t p);
        int sum;
        sum = 76 * int'(p.r) + 150 * int'(p.g) + 26 * int'(p.b);
        return gray_t'(sum / 256);
    endfunction

    function automatic rgb888_t expected_rgb(input filter_mode_t mode, input rgb565_t w);
        rgb888_t p;
        gray_t   y;
        p = widen(w);
        y = gray_level(p);
        if (mode == MODE_GRAY) begin
            p = '{r: y, g: y, b: y};
        end
        return p;
    endfunction

    function automatic string fill_name(input fill_kind_t f);
        case (f)
            FILL_ONES:     return "ones";
            FILL_ZEROS:    return "zeros";
            FILL_BOUNDARY: return "boundary";
            default:       return "random";
        endcase
    endfunction

    // ======================================================================
    // clocking helpers and checks
    // ======================================================================
    // step to just past the next edge where inputs change and outputs are read
    task automatic tick();
        vsync_prev = vsync;
        @(posedge clk_25MHz);
        #(DRIVE_SKEW);
    endtask

    task automatic wait_vsync_fall();
        do tick(); while (!(vsync_prev === 1'b1 && vsync === 1'b0));
    endtask

    task automatic wait_vsync_rise();
        do tick(); while (!(vsync_prev === 1'b0 && vsync === 1'b1));
    endtask

    task automatic report_mismatch(input string name, input int addr,
                                   input logic [31:0] got, input logic [31:0] exp);
        $display("[FAIL] %s at addr %h: got %h, expected %h", name, addr, got, exp);
        errors++;
        test_errs++;
    endtask

    // one write per cycle and bank 1 left alone by the boundary fill
    task automatic write_frame(input fill_kind_t fill);
        rgb565_t data;
        logic    do_write;
        for (int a = 0; a < FRAME_WORDS; a++) begin
            do_write = 1'b1;
            data     = rgb565_t'($urandom());
            if (fill == FILL_ONES) begin
                data = 16'hffff;
            end else if (fill == FILL_ZEROS) begin
                data = 16'h0000;
            end else if (fill == FILL_BOUNDARY) begin
                // pure red, green and blue markers on both sides of the split
                if (a == BANK0_DEPTH - 1) data = 16'hf800;
                if (a == BANK0_DEPTH) data = 16'h07e0;
                if (a == FRAME_WORDS - 1) data = 16'h001f;
                if (a > BANK0_DEPTH && a < FRAME_WORDS - 1) do_write = 1'b0;
            end
            if (do_write) begin
                model[a] = data;
            end
            wr = '{valid: do_write, addr: frame_addr_t'(a), data: data};
            tick();
        end
        wr = '0;
    endtask

    // collect one frame from one vsync fall up to the next
    task automatic check_frame(input test_entry_t t);
        int      count;
        int      cycle;
        int      first_valid;
        int      low_cycles;
        rgb888_t exp;
        count       = 0;
        cycle       = 0;
        first_valid = -1;
        low_cycles  = 0;
        do begin
            tick();
            cycle++;
            if (vsync === 1'b0) begin
                low_cycles++;
            end
            if (pix.valid === 1'b1 && first_valid < 0) begin
                first_valid = cycle;
            end
            if (t.check_en && display_enable !== 1'b1) begin
                report_mismatch("display_enable", count, 32'(display_enable), 32'h1);
            end
            if (vsync === 1'b0 && pix.valid !== 1'b0) begin
                report_mismatch("pix.valid", count, 32'(pix.valid), 32'h0);
            end else if (pix.valid === 1'b1 && count >= FRAME_WORDS) begin
                report_mismatch("pix.addr", count, 32'(pix.addr), 32'(FRAME_WORDS - 1));
                count++;
            end else if (pix.valid === 1'b1) begin
                exp = expected_rgb(t.mode, model[count]);
                if (pix.addr !== frame_addr_t'(count)) begin
                    report_mismatch("pix.addr", count, 32'(pix.addr), 32'(count));
                end
                if (pix.rgb !== exp) begin
                    report_mismatch("pix.rgb", count, 32'(pix.rgb), 32'(exp));
                end
                // gray extremes of full scale and black after widening
                if (t.mode == MODE_GRAY && t.fill == FILL_ONES && pix.rgb !== 24'hfbfbfb) begin
                    report_mismatch("pix.rgb", count, 32'(pix.rgb), 32'hfbfbfb);
                end
                if (t.mode == MODE_GRAY && t.fill == FILL_ZEROS && pix.rgb !== 24'h040404) begin
                    report_mismatch("pix.rgb", count, 32'(pix.rgb), 32'h040404);
                end
                count++;
            end
        end while (!(vsync_prev === 1'b1 && vsync === 1'b0));
        if (count != FRAME_WORDS) begin
            report_mismatch("pix.valid count", 0, 32'(count), 32'(FRAME_WORDS));
        end
        // vsync low for one whole line
        if (low_cycles != H_TOTAL) begin
            report_mismatch("vsync low cycles", 0, 32'(low_cycles), 32'(H_TOTAL));
        end
        // ties the vsync line and the pipeline latency to pixel 0
        if (cycle - first_valid != FIRST_PIX_TO_VSYNC) begin
            report_mismatch("vsync fall after pixel 0", 0, 32'(cycle - first_valid),
                            32'(FIRST_PIX_TO_VSYNC));
        end
    endtask

    // mode, fill and display_enable check
    task automatic load_tests();
        tests[0] = '{mode: MODE_ORIG, fill: FILL_RANDOM, check_en: 1'b1};
        tests[1] = '{mode: MODE_GRAY, fill: FILL_RANDOM, check_en: 1'b1};
        tests[2] = '{mode: MODE_GRAY, fill: FILL_ONES, check_en: 1'b1};
        tests[3] = '{mode: MODE_GRAY, fill: FILL_ZEROS, check_en: 1'b1};
        tests[4] = '{mode: MODE_ORIG, fill: FILL_ONES, check_en: 1'b1};
        tests[5] = '{mode: MODE_ORIG, fill: FILL_BOUNDARY, check_en: 1'b1};
        tests[6] = '{mode: MODE_GRAY, fill: FILL_BOUNDARY, check_en: 1'b1};
        // unused code falls back to the original colour
        tests[7] = '{mode: filter_mode_t'(3'd5), fill: FILL_RANDOM, check_en: 1'b0};
    endtask

    // ======================================================================
    // main sequence
    // ======================================================================
    initial begin
        rst_n        = 1'b0;
        wr           = '0;
        filter_mode  = MODE_ORIG;
        vsync_prev   = 1'b1;
        errors       = 0;
        test_errs    = 0;
        failed_tests = 0;
        void'($urandom(SEED));
        load_tests();

        repeat (4) @(posedge clk_25MHz);
        #(DRIVE_SKEW);
        rst_n = 1'b1;

        // reset values then enable one cycle after the first vsync rise
        if (pix.valid !== 1'b0) report_mismatch("pix.valid", 0, 32'(pix.valid), 32'h0);
        if (vsync !== 1'b1) report_mismatch("vsync", 0, 32'(vsync), 32'h1);
        if (display_enable !== 1'b0) begin
            report_mismatch("display_enable", 0, 32'(display_enable), 32'h0);
        end
        wait_vsync_fall();
        wait_vsync_rise();
        if (display_enable !== 1'b0) begin
            report_mismatch("display_enable", 0, 32'(display_enable), 32'h0);
        end
        tick();
        if (display_enable !== 1'b1) begin
            report_mismatch("display_enable", 0, 32'(display_enable), 32'h1);
        end
        $display("reset and enable: %s", (test_errs == 0) ? "ok" : "failed");
        if (test_errs != 0) failed_tests++;
        wait_vsync_fall();

        for (int i = 0; i < N_TESTS; i++) begin
            test_errs = 0;
            write_frame(tests[i].fill);
            wait_vsync_fall();
            filter_mode = tests[i].mode;
            check_frame(tests[i]);
            $display("test %0d mode %0d fill %s: %s (%0d errors)", i, tests[i].mode,
                     fill_name(tests[i].fill), (test_errs == 0) ? "ok" : "failed", test_errs);
            if (test_errs != 0) failed_tests++;
        end

        $display("%0d tests run, %0d failed, %0d errors", N_TESTS + 1, failed_tests, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
